//--- dcore_pkg.sv
package dcore_pkg;

    ////////////////////
    // widths
    ////////////////////

    // time-interleaved lanes out of the ADC
    localparam int N_TI = 16;
    // ADC code width, two's complement
    localparam int N_ADC = 8;
    // LFSR length for generator and checker
    localparam int N_PRBS = 32;
    // error and total counters
    localparam int N_CNT = 32;

    ////////////////////
    // types
    ////////////////////

    typedef logic signed [N_ADC-1:0] adc_code_t;

    // one bit per lane: data, channel mask, error flags
    typedef logic [N_TI-1:0] lane_bits_t;

    // LFSR state or tap mask
    typedef logic [N_PRBS-1:0] prbs_word_t;

    typedef logic [N_CNT-1:0] cnt_t;

    // generator state out of reset, must be nonzero
    localparam prbs_word_t PRBS_SEED = '1;

    // source of the bits fed to the checker
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } src_sel_t;

    // checker operating mode
    typedef enum logic [1:0] {
        CHK_RESET  = 2'd0,
        CHK_ALIGN  = 2'd1,
        CHK_TEST   = 2'd2,
        CHK_FREEZE = 2'd3
    } chk_mode_t;

endpackage

//--- dcore_prbs_top.sv
`timescale 1ns/1ps

module dcore_prbs_top (
    input  logic                  clk_adc,
    input  logic                  cdr_rstb,
    // ADC slicer
    input  dcore_pkg::adc_code_t  adc_code_i [dcore_pkg::N_TI-1:0],
    input  dcore_pkg::adc_code_t  bit_level_i,
    // BIST generator controls
    input  logic                  gen_cke_i,
    input  logic                  gen_inj_err_i,
    input  logic                  gen_inv_i,
    // tap mask shared by generator and checker
    input  dcore_pkg::prbs_word_t prbs_eqn_i,
    input  dcore_pkg::src_sel_t   sel_src_i,
    // checker controls
    input  logic                  chk_cke_i,
    input  dcore_pkg::chk_mode_t  chk_mode_i,
    input  dcore_pkg::lane_bits_t chan_sel_i,
    // results
    output dcore_pkg::cnt_t       err_count_o,
    output dcore_pkg::cnt_t       total_count_o,
    output dcore_pkg::lane_bits_t prbs_flags_o
);

    logic                  bist_bit;
    dcore_pkg::lane_bits_t rx_bits;

    ////////////////////
    // BIST source
    ////////////////////

    prbs_gen u_prbs_gen (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .cke_i      (gen_cke_i),
        .eqn_i      (prbs_eqn_i),
        .inj_err_i  (gen_inj_err_i),
        .inv_i      (gen_inv_i),
        .bist_bit_o (bist_bit)
    );

    ////////////////////
    // slicer and mux
    ////////////////////

    rx_bit_select u_rx_bit_select (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_code_i  (adc_code_i),
        .bit_level_i (bit_level_i),
        .bist_bit_i  (bist_bit),
        .sel_src_i   (sel_src_i),
        .rx_bits_o   (rx_bits)
    );

    ////////////////////
    // checker
    ////////////////////

    prbs_checker u_prbs_checker (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .cke_i         (chk_cke_i),
        .mode_i        (chk_mode_i),
        .eqn_i         (prbs_eqn_i),
        .chan_sel_i    (chan_sel_i),
        .rx_bits_i     (rx_bits),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o),
        .prbs_flags_o  (prbs_flags_o)
    );

endmodule

//--- list.f
dcore_pkg.sv
prbs_gen.sv
rx_bit_select.sv
prbs_checker.sv
dcore_prbs_top.sv
tb_dcore_prbs.sv

//--- prbs_checker.sv
`timescale 1ns/1ps

module prbs_checker (
    input  logic                  clk_adc,
    input  logic                  cdr_rstb,
    input  logic                  cke_i,
    input  dcore_pkg::chk_mode_t  mode_i,
    input  dcore_pkg::prbs_word_t eqn_i,
    input  dcore_pkg::lane_bits_t chan_sel_i,
    input  dcore_pkg::lane_bits_t rx_bits_i,
    output dcore_pkg::cnt_t       err_count_o,
    output dcore_pkg::cnt_t       total_count_o,
    output dcore_pkg::lane_bits_t prbs_flags_o
);

    dcore_pkg::prbs_word_t hist_q [dcore_pkg::N_TI-1:0];
    dcore_pkg::lane_bits_t err_bits;
    dcore_pkg::lane_bits_t masked_err;
    dcore_pkg::lane_bits_t flags_q;
    dcore_pkg::cnt_t       err_cnt_q;
    dcore_pkg::cnt_t       total_cnt_q;
    dcore_pkg::cnt_t       err_cnt_next;
    dcore_pkg::cnt_t       total_cnt_next;

    // number of set bits across the lanes
    function automatic dcore_pkg::cnt_t popcount(input dcore_pkg::lane_bits_t bits);
        dcore_pkg::cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < dcore_pkg::N_TI; i++) begin
            cnt = cnt + dcore_pkg::cnt_t'(bits[i]);
        end
        return cnt;
    endfunction

    // add that sticks at all ones instead of wrapping
    function automatic dcore_pkg::cnt_t sat_add(input dcore_pkg::cnt_t a,
                                                input dcore_pkg::cnt_t b);
        logic [dcore_pkg::N_CNT:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[dcore_pkg::N_CNT] ? '1 : sum[dcore_pkg::N_CNT-1:0];
    endfunction

    ////////////////////
    // prediction
    ////////////////////

    // each lane predicts from its own history, so no seed is needed
    always_comb begin
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            err_bits[k] = rx_bits_i[k] ^ (^(hist_q[k] & eqn_i));
        end
    end

    assign masked_err     = err_bits & chan_sel_i;
    assign err_cnt_next   = sat_add(err_cnt_q, popcount(masked_err));
    assign total_cnt_next = sat_add(total_cnt_q, popcount(chan_sel_i));

    ////////////////////
    // lane histories
    ////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                hist_q[k] <= '0;
            end
        end else if (cke_i) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                if (mode_i == dcore_pkg::CHK_RESET) begin
                    hist_q[k] <= '0;
                end else begin
                    hist_q[k] <= {hist_q[k][dcore_pkg::N_PRBS-2:0], rx_bits_i[k]};
                end
            end
        end
    end

    ////////////////////
    // counters and flags
    ////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_cnt_q   <= '0;
            total_cnt_q <= '0;
            flags_q     <= '0;
        end else if (cke_i) begin
            case (mode_i)
                dcore_pkg::CHK_RESET: begin
                    err_cnt_q   <= '0;
                    total_cnt_q <= '0;
                    flags_q     <= '0;
                end
                dcore_pkg::CHK_ALIGN: begin
                    // counters hold while the histories fill
                    flags_q <= '0;
                end
                dcore_pkg::CHK_TEST: begin
                    err_cnt_q   <= err_cnt_next;
                    total_cnt_q <= total_cnt_next;
                    flags_q     <= masked_err;
                end
                dcore_pkg::CHK_FREEZE: begin
                    // keep last result for readout
                    flags_q <= flags_q;
                end
            endcase
        end
    end

    assign err_count_o   = err_cnt_q;
    assign total_count_o = total_cnt_q;
    assign prbs_flags_o  = flags_q;

endmodule

//--- prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic                  clk_adc,
    input  logic                  cdr_rstb,
    input  logic                  cke_i,
    input  dcore_pkg::prbs_word_t eqn_i,
    input  logic                  inj_err_i,
    input  logic                  inv_i,
    output logic                  bist_bit_o
);

    dcore_pkg::prbs_word_t state_q;
    logic                  feedback;
    logic                  out_q;

    ////////////////////
    // Fibonacci LFSR
    ////////////////////

    // parity over the tapped state bits
    assign feedback = ^(state_q & eqn_i);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= dcore_pkg::PRBS_SEED;
        end else if (cke_i) begin
            // shift up, new bit enters at the bottom
            state_q <= {state_q[dcore_pkg::N_PRBS-2:0], feedback};
        end
    end

    ////////////////////
    // output bit
    ////////////////////

    // inj_err flips just this one bit, inv flips the whole stream
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            out_q <= 1'b0;
        end else if (cke_i) begin
            out_q <= feedback ^ inj_err_i ^ inv_i;
        end
    end

    assign bist_bit_o = out_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the PRBS testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_dcore_prbs -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_dcore_prbs 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- rx_bit_select.sv
`timescale 1ns/1ps

module rx_bit_select (
    input  logic                 clk_adc,
    input  logic                 cdr_rstb,
    input  dcore_pkg::adc_code_t adc_code_i [dcore_pkg::N_TI-1:0],
    input  dcore_pkg::adc_code_t bit_level_i,
    input  logic                 bist_bit_i,
    input  dcore_pkg::src_sel_t  sel_src_i,
    output dcore_pkg::lane_bits_t rx_bits_o
);

    dcore_pkg::lane_bits_t sliced_bits;
    dcore_pkg::lane_bits_t sel_bits;
    dcore_pkg::lane_bits_t rx_bits_q;

    ////////////////////
    // ADC slicer
    ////////////////////

    // signed compare of each code against the programmable level
    always_comb begin
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            sliced_bits[k] = (adc_code_i[k] > bit_level_i);
        end
    end

    ////////////////////
    // source mux
    ////////////////////

    // BIST stream is a single serial bit, copied onto every lane
    always_comb begin
        if (sel_src_i == dcore_pkg::SRC_BIST) begin
            sel_bits = {dcore_pkg::N_TI{bist_bit_i}};
        end else begin
            sel_bits = sliced_bits;
        end
    end

    // one register stage before the checker
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rx_bits_q <= '0;
        end else begin
            rx_bits_q <= sel_bits;
        end
    end

    assign rx_bits_o = rx_bits_q;

endmodule

//--- tb_dcore_prbs.sv
`timescale 1ns/1ps

module tb_dcore_prbs;

    localparam int RST_CYCLES     = 3;
    localparam int CLR_CYCLES     = 10;
    localparam int ALIGN_CYCLES   = 40;
    localparam int TEST_CYCLES    = 200;
    localparam int INJ_CYCLES     = 150;
    localparam int FREEZE_CYCLES  = 100;
    localparam int ADC_CYCLES     = 150;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + CLR_CYCLES + ALIGN_CYCLES + TEST_CYCLES
                                  + INJ_CYCLES + FREEZE_CYCLES + ADC_CYCLES + 50;
    // PRBS31 taps for x^31 + x^28 + 1
    localparam dcore_pkg::prbs_word_t PRBS31_EQN = 32'h4800_0000;

    logic                  clk_adc;
    logic                  cdr_rstb;
    dcore_pkg::adc_code_t  adc_code [dcore_pkg::N_TI-1:0];
    dcore_pkg::adc_code_t  bit_level;
    logic                  gen_cke;
    logic                  gen_inj_err;
    logic                  gen_inv;
    dcore_pkg::prbs_word_t prbs_eqn;
    dcore_pkg::src_sel_t   sel_src;
    logic                  chk_cke;
    dcore_pkg::chk_mode_t  chk_mode;
    dcore_pkg::lane_bits_t chan_sel;
    dcore_pkg::cnt_t       err_count;
    dcore_pkg::cnt_t       total_count;
    dcore_pkg::lane_bits_t prbs_flags;

    // reference model state
    dcore_pkg::prbs_word_t m_state;
    logic                  m_out;
    dcore_pkg::lane_bits_t m_rx;
    dcore_pkg::prbs_word_t m_hist [dcore_pkg::N_TI-1:0];
    dcore_pkg::cnt_t       m_err;
    dcore_pkg::cnt_t       m_tot;
    dcore_pkg::lane_bits_t m_flags;

    logic [31:0] lcg_state = 32'he96a_a210;
    int          error_cnt = 0;
    int          cycle_cnt = 0;

    dcore_prbs_top u_dut (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_code_i    (adc_code),
        .bit_level_i   (bit_level),
        .gen_cke_i     (gen_cke),
        .gen_inj_err_i (gen_inj_err),
        .gen_inv_i     (gen_inv),
        .prbs_eqn_i    (prbs_eqn),
        .sel_src_i     (sel_src),
        .chk_cke_i     (chk_cke),
        .chk_mode_i    (chk_mode),
        .chan_sel_i    (chan_sel),
        .err_count_o   (err_count),
        .total_count_o (total_count),
        .prbs_flags_o  (prbs_flags)
    );

    initial begin
        clk_adc = 1'b0;
        forever #20 clk_adc = ~clk_adc;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // xor of the state bits picked by the tap mask
    function automatic logic tap_parity(input dcore_pkg::prbs_word_t word,
                                        input dcore_pkg::prbs_word_t mask);
        logic p;
        p = 1'b0;
        for (int i = 0; i < dcore_pkg::N_PRBS; i++) begin
            if (mask[i]) begin
                p = p ^ word[i];
            end
        end
        return p;
    endfunction

    function automatic int count_ones(input dcore_pkg::lane_bits_t bits);
        int n;
        n = 0;
        for (int i = 0; i < dcore_pkg::N_TI; i++) begin
            if (bits[i]) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    // counter add clamped at all ones
    function automatic dcore_pkg::cnt_t add_clamped(input dcore_pkg::cnt_t cnt, input int n);
        longint sum;
        sum = longint'(cnt) + longint'(n);
        if (sum > 64'hffff_ffff) begin
            return '1;
        end
        return dcore_pkg::cnt_t'(sum);
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_cnt = error_cnt + 1;
            $display("FAILED at time %0t: %s mismatch, expected %0h got %0h",
                     $time, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    task automatic model_reset();
        m_state = dcore_pkg::PRBS_SEED;
        m_out   = 1'b0;
        m_rx    = '0;
        m_err   = '0;
        m_tot   = '0;
        m_flags = '0;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            m_hist[k] = '0;
        end
    endtask

    // one clock edge with the checker first so each stage sees the older value
    task automatic model_step();
        dcore_pkg::lane_bits_t errs;
        logic                  fb;
        if (chk_cke) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                errs[k] = m_rx[k] ^ tap_parity(m_hist[k], prbs_eqn);
            end
            errs = errs & chan_sel;
            if (chk_mode == dcore_pkg::CHK_RESET) begin
                m_err   = '0;
                m_tot   = '0;
                m_flags = '0;
            end else if (chk_mode == dcore_pkg::CHK_ALIGN) begin
                m_flags = '0;
            end else if (chk_mode == dcore_pkg::CHK_TEST) begin
                m_err   = add_clamped(m_err, count_ones(errs));
                m_tot   = add_clamped(m_tot, count_ones(chan_sel));
                m_flags = errs;
            end
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                if (chk_mode == dcore_pkg::CHK_RESET) begin
                    m_hist[k] = '0;
                end else begin
                    m_hist[k] = {m_hist[k][dcore_pkg::N_PRBS-2:0], m_rx[k]};
                end
            end
        end
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            if (sel_src == dcore_pkg::SRC_BIST) begin
                m_rx[k] = m_out;
            end else begin
                m_rx[k] = (int'(adc_code[k]) > int'(bit_level));
            end
        end
        if (gen_cke) begin
            fb      = tap_parity(m_state, prbs_eqn);
            m_out   = fb ^ gen_inj_err ^ gen_inv;
            m_state = {m_state[dcore_pkg::N_PRBS-2:0], fb};
        end
    endtask

    task automatic compare_outputs();
        check_value("err_count_o", 64'(m_err), 64'(err_count));
        check_value("total_count_o", 64'(m_tot), 64'(total_count));
        check_value("prbs_flags_o", 64'(m_flags), 64'(prbs_flags));
    endtask

    // edge, model update, compare, then leave at the drive point
    task automatic run_cycle();
        @(posedge clk_adc);
        model_step();
        #1;
        compare_outputs();
        #1;
    endtask

    always @(posedge clk_adc) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin : stimulus
        logic [31:0]     r;
        dcore_pkg::cnt_t held_err;
        dcore_pkg::cnt_t held_tot;
        cdr_rstb    = 1'b0;
        bit_level   = '0;
        gen_cke     = 1'b0;
        gen_inj_err = 1'b0;
        gen_inv     = 1'b0;
        prbs_eqn    = PRBS31_EQN;
        sel_src     = dcore_pkg::SRC_BIST;
        chk_cke     = 1'b1;
        chk_mode    = dcore_pkg::CHK_RESET;
        chan_sel    = '1;
        for (int k = 0; k < dcore_pkg::N_TI; k++) begin
            adc_code[k] = '0;
        end
        model_reset();
        repeat (RST_CYCLES) @(posedge clk_adc);
        #2;
        cdr_rstb = 1'b1;
        check_value("err_count_o after reset", 64'd0, 64'(err_count));
        check_value("total_count_o after reset", 64'd0, 64'(total_count));
        check_value("prbs_flags_o after reset", 64'd0, 64'(prbs_flags));

        // counters stay cleared in reset mode even with random lane bits arriving
        sel_src = dcore_pkg::SRC_ADC;
        repeat (CLR_CYCLES) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                r           = next_rand();
                adc_code[k] = dcore_pkg::adc_code_t'(r[23:16]);
            end
            run_cycle();
            check_value("err_count_o in reset mode", 64'd0, 64'(err_count));
            check_value("total_count_o in reset mode", 64'd0, 64'(total_count));
            check_value("prbs_flags_o in reset mode", 64'd0, 64'(prbs_flags));
        end

        // clean BIST stream, align then count
        sel_src  = dcore_pkg::SRC_BIST;
        gen_cke  = 1'b1;
        chk_mode = dcore_pkg::CHK_ALIGN;
        repeat (ALIGN_CYCLES) run_cycle();
        chk_mode = dcore_pkg::CHK_TEST;
        repeat (TEST_CYCLES) run_cycle();
        check_value("err_count_o clean lock", 64'd0, 64'(err_count));
        check_value("total_count_o clean lock", 64'(dcore_pkg::N_TI * TEST_CYCLES),
                    64'(total_count));

        // random error pulses, lane masks and generator stalls
        repeat (INJ_CYCLES) begin
            r           = next_rand();
            gen_inj_err = (r[2:0] == 3'd0);
            gen_cke     = (r[7:4] != 4'd0);
            chan_sel    = dcore_pkg::lane_bits_t'(r[31:16]);
            run_cycle();
        end

        // inverted stream into a frozen checker
        gen_inj_err = 1'b0;
        gen_cke     = 1'b1;
        gen_inv     = 1'b1;
        chk_mode    = dcore_pkg::CHK_FREEZE;
        held_err    = err_count;
        held_tot    = total_count;
        repeat (FREEZE_CYCLES) begin
            r       = next_rand();
            chk_cke = r[9];
            run_cycle();
        end
        check_value("err_count_o held in freeze", 64'(held_err), 64'(err_count));
        check_value("total_count_o held in freeze", 64'(held_tot), 64'(total_count));

        // sliced ADC codes
        chk_cke  = 1'b1;
        sel_src  = dcore_pkg::SRC_ADC;
        chk_mode = dcore_pkg::CHK_TEST;
        r        = next_rand();
        bit_level = dcore_pkg::adc_code_t'(r[15:8]);
        repeat (ADC_CYCLES) begin
            for (int k = 0; k < dcore_pkg::N_TI; k++) begin
                r           = next_rand();
                adc_code[k] = dcore_pkg::adc_code_t'(r[23:16]);
            end
            r        = next_rand();
            chan_sel = dcore_pkg::lane_bits_t'(r[27:12]);
            run_cycle();
        end

        if (error_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule
